// ==== hdl/bram_uart_pkg.sv ====
package bram_uart_pkg;

localparam int MEM_WIDTH = 32;

// Word addresses, the same values act as command codes
localparam int CTRL_ADDR    = 0;
localparam int DIVIDER_ADDR = 1;
localparam int PARITY_ADDR  = 2;
localparam int TX_DATA_ADDR = 3;
localparam int RX_DATA_ADDR = 4;

typedef enum logic [1:0] {
    PARITY_NONE = 2'd0,
    PARITY_EVEN = 2'd1,
    PARITY_ODD  = 2'd2
} parity_e;

// One memory word, decoded according to the register it came from
typedef union packed {
    struct packed {
        logic [MEM_WIDTH-17:0] unused;
        logic [15:0]           divider;
    } div;
    struct packed {
        logic [MEM_WIDTH-3:0] unused;
        parity_e              parity;
    } par;
    struct packed {
        logic [MEM_WIDTH-9:0] unused;
        logic [7:0]           data;
    } chr;
} mem_word_u;

endpackage

// ==== hdl/bram_uart_fifo.sv ====
`timescale 1ns/1ps

module bram_uart_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             arstn_i,
    input  logic [WIDTH-1:0] s_data_i,
    input  logic             s_valid_i,
    output logic             s_ready_o,
    output logic [WIDTH-1:0] m_data_o,
    output logic             m_valid_o,
    input  logic             m_ready_i
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic [WIDTH-1:0] mem_q [DEPTH];
logic [PTR_W-1:0] wr_ptr_q;
logic [PTR_W-1:0] rd_ptr_q;
logic [CNT_W-1:0] count_q;
logic             push;
logic             pop;

assign s_ready_o = (count_q != CNT_W'(DEPTH));
assign m_valid_o = (count_q != '0);
assign m_data_o  = mem_q[rd_ptr_q];
assign push      = s_valid_i & s_ready_o;
assign pop       = m_valid_o & m_ready_i;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (push) begin
        mem_q[wr_ptr_q] <= s_data_i;
    end
end

endmodule

// ==== hdl/bram_uart_tx.sv ====
`timescale 1ns/1ps

module bram_uart_tx
    import bram_uart_pkg::*;
(
    input  logic        clk_i,
    input  logic        arstn_i,
    input  logic [15:0] divider_i,
    input  parity_e     parity_i,
    input  logic [7:0]  s_data_i,
    input  logic        s_valid_i,
    output logic        s_ready_o,
    output logic        uart_tx_o
);

typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
} state_e;

state_e      state_q;
logic [15:0] cnt_q;
logic [2:0]  bit_q;
logic [7:0]  shift_q;
logic        par_q;
logic        par_en;
logic        bit_end;

assign s_ready_o = (state_q == IDLE);
assign bit_end   = (cnt_q == divider_i - 16'd1);
assign par_en    = (parity_i == PARITY_EVEN) || (parity_i == PARITY_ODD);

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        state_q   <= IDLE;
        cnt_q     <= '0;
        bit_q     <= '0;
        uart_tx_o <= 1'b1;
    end else begin
        cnt_q <= (bit_end || state_q == IDLE) ? '0 : cnt_q + 16'd1;
        case (state_q)
            IDLE: begin
                if (s_valid_i) begin
                    state_q   <= START;
                    uart_tx_o <= 1'b0;
                end
            end
            START: begin
                if (bit_end) begin
                    state_q   <= DATA;
                    bit_q     <= '0;
                    uart_tx_o <= shift_q[0];
                end
            end
            DATA: begin
                if (bit_end) begin
                    bit_q <= bit_q + 3'd1;
                    if (bit_q != 3'd7) begin
                        uart_tx_o <= shift_q[1];
                    end else if (par_en) begin
                        state_q   <= PARITY;
                        uart_tx_o <= par_q;
                    end else begin
                        state_q   <= STOP;
                        uart_tx_o <= 1'b1;
                    end
                end
            end
            PARITY: begin
                if (bit_end) begin
                    state_q   <= STOP;
                    uart_tx_o <= 1'b1;
                end
            end
            STOP: begin
                if (bit_end) begin
                    state_q <= IDLE;
                end
            end
            default: state_q <= IDLE;
        endcase
    end
end

// Even parity bit equals the XOR of the data, odd parity its inverse
always_ff @(posedge clk_i) begin
    if (s_valid_i && s_ready_o) begin
        shift_q <= s_data_i;
        par_q   <= (^s_data_i) ^ (parity_i == PARITY_ODD);
    end else if (state_q == DATA && bit_end) begin
        shift_q <= shift_q >> 1;
    end
end

endmodule

// ==== hdl/bram_uart_rx.sv ====
`timescale 1ns/1ps

module bram_uart_rx
    import bram_uart_pkg::*;
(
    input  logic        clk_i,
    input  logic        arstn_i,
    input  logic [15:0] divider_i,
    input  parity_e     parity_i,
    input  logic        uart_rx_i,
    output logic [7:0]  m_data_o,
    output logic        m_valid_o
);

typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
} state_e;

state_e      state_q;
logic [2:0]  sync_q;
logic [15:0] cnt_q;
logic [2:0]  bit_q;
logic [7:0]  shift_q;
logic        par_ok_q;
logic        rx_s;
logic        fall;
logic        par_en;
logic        sample;

// Two synchronizer flops, the third keeps the previous level for edge detection
assign rx_s   = sync_q[1];
assign fall   = sync_q[2] & ~sync_q[1];
assign par_en = (parity_i == PARITY_EVEN) || (parity_i == PARITY_ODD);
// Start bit checked at mid-bit, then one sample per bit period
assign sample = (state_q == START) ? (cnt_q == (divider_i >> 1))
                                   : (cnt_q == divider_i - 16'd1);

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        state_q   <= IDLE;
        sync_q    <= '1;
        cnt_q     <= '0;
        bit_q     <= '0;
        par_ok_q  <= 1'b0;
        m_valid_o <= 1'b0;
    end else begin
        sync_q    <= {sync_q[1:0], uart_rx_i};
        m_valid_o <= 1'b0;
        cnt_q     <= (sample || state_q == IDLE) ? '0 : cnt_q + 16'd1;
        case (state_q)
            IDLE: begin
                if (fall) begin
                    state_q <= START;
                end
            end
            START: begin
                if (sample) begin
                    // Line back high means a glitch, not a start bit
                    state_q  <= rx_s ? IDLE : DATA;
                    bit_q    <= '0;
                    par_ok_q <= 1'b1;
                end
            end
            DATA: begin
                if (sample) begin
                    bit_q <= bit_q + 3'd1;
                    if (bit_q == 3'd7) begin
                        state_q <= par_en ? PARITY : STOP;
                    end
                end
            end
            PARITY: begin
                if (sample) begin
                    par_ok_q <= (rx_s == ((^shift_q) ^ (parity_i == PARITY_ODD)));
                    state_q  <= STOP;
                end
            end
            STOP: begin
                if (sample) begin
                    m_valid_o <= rx_s & par_ok_q;
                    state_q   <= IDLE;
                end
            end
            default: state_q <= IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (state_q == DATA && sample) begin
        shift_q <= {rx_s, shift_q[7:1]};
    end
end

assign m_data_o = shift_q;

endmodule

// ==== hdl/bram_uart_dpram.sv ====
`timescale 1ns/1ps

module bram_uart_dpram
    import bram_uart_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 4
) (
    input  logic                      clk_i,
    input  logic                      arstn_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [MEM_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [MEM_WIDTH-1:0]      wb_dat_i,
    input  logic [MEM_WIDTH/8-1:0]    wb_sel_i,
    output logic [MEM_WIDTH-1:0]      wb_dat_o,
    output logic                      wb_ack_o,
    input  logic [MEM_ADDR_WIDTH-1:0] b_addr_i,
    input  logic [MEM_WIDTH-1:0]      b_wdata_i,
    input  logic                      b_we_i,
    output logic [MEM_WIDTH-1:0]      b_rdata_o
);

localparam int WORDS = 2 ** MEM_ADDR_WIDTH;
localparam int LANES = MEM_WIDTH / 8;

logic [MEM_WIDTH-1:0] mem_q [WORDS];
logic                 ack_q;
logic                 wb_req;

assign wb_req   = wb_cyc_i & wb_stb_i & ~ack_q;
// A dropped strobe takes the ack away in the same cycle
assign wb_ack_o = ack_q & wb_cyc_i & wb_stb_i;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        ack_q <= 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            mem_q[i] <= '0;
        end
    end else begin
        ack_q <= wb_req;
        if (wb_req && wb_we_i) begin
            for (int l = 0; l < LANES; l++) begin
                if (wb_sel_i[l]) begin
                    mem_q[wb_adr_i][l*8 +: 8] <= wb_dat_i[l*8 +: 8];
                end
            end
        end
        if (b_we_i) begin
            mem_q[b_addr_i] <= b_wdata_i;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (wb_req) begin
        wb_dat_o <= mem_q[wb_adr_i];
    end
    b_rdata_o <= mem_q[b_addr_i];
end

endmodule

// ==== hdl/bram_uart_ctrl.sv ====
`timescale 1ns/1ps

module bram_uart_ctrl
    import bram_uart_pkg::*;
#(
    parameter int FIFO_DEPTH     = 8,
    parameter int MEM_ADDR_WIDTH = 4
) (
    input  logic                      clk_i,
    input  logic                      arstn_i,
    input  logic [MEM_WIDTH-1:0]      mem_rdata_i,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr_o,
    output logic [MEM_WIDTH-1:0]      mem_wdata_o,
    output logic                      mem_we_o,
    input  logic                      uart_rx_i,
    output logic                      uart_tx_o
);

localparam logic [15:0] DIVIDER_RESET = 16'd16;

typedef enum logic [3:0] {
    ST_POLL,
    ST_POLL_WAIT,
    ST_DECODE,
    ST_FETCH,
    ST_WAIT,
    ST_LOAD,
    ST_TX_PUSH,
    ST_RX_WAIT,
    ST_DONE,
    ST_CLEAR
} state_e;

state_e      state_q;
mem_word_u   rd_word;
logic [15:0] divider_q;
parity_e     parity_q;
logic [7:0]  tx_data_q;
logic        tx_valid_q;
logic        tx_ready;
logic [7:0]  txf_data;
logic        txf_valid;
logic        txf_ready;
logic [7:0]  rx_data;
logic        rx_valid;
logic [7:0]  rxf_data;
logic        rxf_valid;
logic        rxf_ready;

assign rd_word   = mem_rdata_i;
assign rxf_ready = (state_q == ST_RX_WAIT);

// ##############################
// Command sequencer
// ##############################

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        state_q     <= ST_POLL;
        mem_addr_o  <= MEM_ADDR_WIDTH'(CTRL_ADDR);
        mem_wdata_o <= '0;
        mem_we_o    <= 1'b0;
        divider_q   <= DIVIDER_RESET;
        parity_q    <= PARITY_NONE;
        tx_valid_q  <= 1'b0;
    end else begin
        case (state_q)
            ST_POLL: begin
                mem_addr_o <= MEM_ADDR_WIDTH'(CTRL_ADDR);
                state_q    <= ST_POLL_WAIT;
            end
            ST_POLL_WAIT: state_q <= ST_DECODE;
            ST_DECODE: begin
                case (mem_rdata_i)
                    MEM_WIDTH'(DIVIDER_ADDR),
                    MEM_WIDTH'(PARITY_ADDR),
                    MEM_WIDTH'(TX_DATA_ADDR): begin
                        // Command code doubles as the target word address
                        mem_addr_o <= mem_rdata_i[MEM_ADDR_WIDTH-1:0];
                        state_q    <= ST_FETCH;
                    end
                    MEM_WIDTH'(RX_DATA_ADDR): state_q <= ST_RX_WAIT;
                    // Idle or unknown code stays in place
                    default: state_q <= ST_POLL;
                endcase
            end
            ST_FETCH: state_q <= ST_WAIT;
            ST_WAIT:  state_q <= ST_LOAD;
            ST_LOAD: begin
                if (mem_addr_o == MEM_ADDR_WIDTH'(DIVIDER_ADDR)) begin
                    divider_q <= rd_word.div.divider;
                    state_q   <= ST_DONE;
                end else if (mem_addr_o == MEM_ADDR_WIDTH'(PARITY_ADDR)) begin
                    parity_q <= rd_word.par.parity;
                    state_q  <= ST_DONE;
                end else begin
                    tx_valid_q <= 1'b1;
                    state_q    <= ST_TX_PUSH;
                end
            end
            // Stalls here while the TX FIFO is full
            ST_TX_PUSH: begin
                if (tx_valid_q && tx_ready) begin
                    tx_valid_q <= 1'b0;
                    state_q    <= ST_DONE;
                end
            end
            ST_RX_WAIT: begin
                if (rxf_valid) begin
                    mem_addr_o  <= MEM_ADDR_WIDTH'(RX_DATA_ADDR);
                    mem_wdata_o <= MEM_WIDTH'(rxf_data);
                    mem_we_o    <= 1'b1;
                    state_q     <= ST_DONE;
                end
            end
            ST_DONE: begin
                mem_addr_o  <= MEM_ADDR_WIDTH'(CTRL_ADDR);
                mem_wdata_o <= '0;
                mem_we_o    <= 1'b1;
                state_q     <= ST_CLEAR;
            end
            ST_CLEAR: begin
                mem_we_o <= 1'b0;
                state_q  <= ST_POLL;
            end
            default: state_q <= ST_POLL;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (state_q == ST_LOAD) begin
        tx_data_q <= rd_word.chr.data;
    end
end

// ##############################
// FIFOs and bit engines
// ##############################

bram_uart_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .WIDTH     (8         )
) u_tx_fifo (
    .clk_i     (clk_i     ),
    .arstn_i   (arstn_i   ),
    .s_data_i  (tx_data_q ),
    .s_valid_i (tx_valid_q),
    .s_ready_o (tx_ready  ),
    .m_data_o  (txf_data  ),
    .m_valid_o (txf_valid ),
    .m_ready_i (txf_ready )
);

bram_uart_tx u_tx (
    .clk_i     (clk_i     ),
    .arstn_i   (arstn_i   ),
    .divider_i (divider_q ),
    .parity_i  (parity_q  ),
    .s_data_i  (txf_data  ),
    .s_valid_i (txf_valid ),
    .s_ready_o (txf_ready ),
    .uart_tx_o (uart_tx_o )
);

bram_uart_rx u_rx (
    .clk_i     (clk_i     ),
    .arstn_i   (arstn_i   ),
    .divider_i (divider_q ),
    .parity_i  (parity_q  ),
    .uart_rx_i (uart_rx_i ),
    .m_data_o  (rx_data   ),
    .m_valid_o (rx_valid  )
);

// No back-pressure toward the deserializer, a full FIFO drops the byte
bram_uart_fifo #(
    .DEPTH     (FIFO_DEPTH),
    .WIDTH     (8         )
) u_rx_fifo (
    .clk_i     (clk_i     ),
    .arstn_i   (arstn_i   ),
    .s_data_i  (rx_data   ),
    .s_valid_i (rx_valid  ),
    .s_ready_o (          ),
    .m_data_o  (rxf_data  ),
    .m_valid_o (rxf_valid ),
    .m_ready_i (rxf_ready )
);

endmodule

// ==== hdl/bram_uart_top.sv ====
`timescale 1ns/1ps

module bram_uart_top
    import bram_uart_pkg::*;
#(
    parameter int FIFO_DEPTH     = 8,
    parameter int MEM_ADDR_WIDTH = 4
) (
    input  logic                      clk_i,
    input  logic                      arstn_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [MEM_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [MEM_WIDTH-1:0]      wb_dat_i,
    input  logic [MEM_WIDTH/8-1:0]    wb_sel_i,
    output logic [MEM_WIDTH-1:0]      wb_dat_o,
    output logic                      wb_ack_o,
    input  logic                      uart_rx_i,
    output logic                      uart_tx_o
);

logic [MEM_ADDR_WIDTH-1:0] mem_addr;
logic [MEM_WIDTH-1:0]      mem_wdata;
logic [MEM_WIDTH-1:0]      mem_rdata;
logic                      mem_we;

bram_uart_dpram #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
) u_dpram (
    .clk_i     (clk_i    ),
    .arstn_i   (arstn_i  ),
    .wb_cyc_i  (wb_cyc_i ),
    .wb_stb_i  (wb_stb_i ),
    .wb_we_i   (wb_we_i  ),
    .wb_adr_i  (wb_adr_i ),
    .wb_dat_i  (wb_dat_i ),
    .wb_sel_i  (wb_sel_i ),
    .wb_dat_o  (wb_dat_o ),
    .wb_ack_o  (wb_ack_o ),
    .b_addr_i  (mem_addr ),
    .b_wdata_i (mem_wdata),
    .b_we_i    (mem_we   ),
    .b_rdata_o (mem_rdata)
);

bram_uart_ctrl #(
    .FIFO_DEPTH     (FIFO_DEPTH    ),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
) u_ctrl (
    .clk_i       (clk_i    ),
    .arstn_i     (arstn_i  ),
    .mem_rdata_i (mem_rdata),
    .mem_addr_o  (mem_addr ),
    .mem_wdata_o (mem_wdata),
    .mem_we_o    (mem_we   ),
    .uart_rx_i   (uart_rx_i),
    .uart_tx_o   (uart_tx_o)
);

endmodule

// ==== tb/bram_uart_properties.sv ====
`timescale 1ns/1ps

module bram_uart_properties (
    input logic clk_i,
    input logic arstn_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic uart_tx_o
);

logic [2:0] since_rst_q;
int         fail_count;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        since_rst_q <= '0;
    end else if (since_rst_q != 3'd4) begin
        since_rst_q <= since_rst_q + 3'd1;
    end
end

// Host side samples ack on the falling edge
ack_needs_stb: assert property (@(negedge clk_i) wb_ack_o |-> wb_stb_i)
    else begin
        $error("wb_ack_o is high while wb_stb_i is low");
        fail_count++;
    end

ack_single: assert property (@(negedge clk_i) wb_ack_o |=> !wb_ack_o)
    else begin
        $error("wb_ack_o stays high for more than one cycle");
        fail_count++;
    end

// Line idle through reset and the first 4 cycles after it
tx_idle_reset: assert property (@(negedge clk_i) (since_rst_q != 3'd4) |-> uart_tx_o)
    else begin
        $error("uart_tx_o is low during or right after reset");
        fail_count++;
    end

endmodule

bind bram_uart_top bram_uart_properties u_properties (
    .clk_i     (clk_i    ),
    .arstn_i   (arstn_i  ),
    .wb_stb_i  (wb_stb_i ),
    .wb_ack_o  (wb_ack_o ),
    .uart_tx_o (uart_tx_o)
);

// ==== tb/bram_uart_tb.sv ====
`timescale 1ns/1ps

module bram_uart_tb
    import bram_uart_pkg::*;
();

// Well above the total frame time of all tests at divider 16
localparam int TIMEOUT_CYCLES = 40000;
localparam int BIT_CYCLES     = 16;

logic        clk = 1'b0;
logic        arstn;
logic        wb_cyc;
logic        wb_stb;
logic        wb_we;
logic [3:0]  wb_adr;
logic [31:0] wb_dat_w;
logic [3:0]  wb_sel;
logic [31:0] wb_dat_r;
logic        wb_ack;
logic        uart_tx;
logic        uart_rx;
logic        loop_en;
logic        inj_line;
int          cycle_cnt;
int          n_tests;
int          n_checks;
int          n_errors;
logic [31:0] shadow [16];

// Serial loopback, opened to inject frames by hand
assign uart_rx = loop_en ? uart_tx : inj_line;

always #5 clk = ~clk;

bram_uart_top #(
    .FIFO_DEPTH     (8),
    .MEM_ADDR_WIDTH (4)
) u_bram_uart_top (
    .clk_i     (clk     ),
    .arstn_i   (arstn   ),
    .wb_cyc_i  (wb_cyc  ),
    .wb_stb_i  (wb_stb  ),
    .wb_we_i   (wb_we   ),
    .wb_adr_i  (wb_adr  ),
    .wb_dat_i  (wb_dat_w),
    .wb_sel_i  (wb_sel  ),
    .wb_dat_o  (wb_dat_r),
    .wb_ack_o  (wb_ack  ),
    .uart_rx_i (uart_rx ),
    .uart_tx_o (uart_tx )
);

// ##############################
// Host and check tasks
// ##############################

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        n_errors++;
    end
endtask

task automatic finish_test(input string name, input int err_start);
    n_tests++;
    if (n_errors == err_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d failed checks", name, n_errors - err_start);
    end
endtask

task automatic wb_write(input logic [3:0] adr, input logic [31:0] data, input logic [3:0] sel);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wb_sel   = sel;
    do begin
        @(negedge clk);
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do begin
        @(negedge clk);
    end while (!wb_ack);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

// Completion shows as a zero control word
task automatic wait_idle();
    logic [31:0] ctrl;
    do begin
        wb_read(4'(CTRL_ADDR), ctrl);
    end while (ctrl != '0);
endtask

task automatic run_cmd(input int cmd);
    wb_write(4'(CTRL_ADDR), 32'(cmd), 4'hf);
    wait_idle();
endtask

task automatic load_config(input int adr, input logic [31:0] value);
    wb_write(4'(adr), value, 4'hf);
    run_cmd(adr);
endtask

task automatic loop_byte(input string name, input logic [7:0] data);
    logic [31:0] rd;
    wb_write(4'(TX_DATA_ADDR), {24'h0, data}, 4'hf);
    run_cmd(TX_DATA_ADDR);
    run_cmd(RX_DATA_ADDR);
    wb_read(4'(RX_DATA_ADDR), rd);
    check_value(name, {24'h0, data}, rd);
endtask

// Start bit, data LSB first, parity bit, stop bit
task automatic send_frame(input logic [7:0] data, input logic par_bit);
    logic [10:0] bits;
    bits = {1'b1, par_bit, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
        inj_line = bits[i];
        repeat (BIT_CYCLES) @(negedge clk);
    end
endtask

initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle_cnt++;
    end
    $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
end

// ##############################
// Tests
// ##############################

initial begin
    int          err_start;
    int          low;
    logic [31:0] rd;
    logic [31:0] wd;
    logic [3:0]  sel;
    logic [3:0]  adr;
    logic [7:0]  sent [3];
    logic [7:0]  good;
    logic [7:0]  bad;

    void'($urandom(32'h4b8f));
    arstn    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    loop_en  = 1'b1;
    inj_line = 1'b1;
    repeat (3) @(negedge clk);
    arstn = 1'b1;

    err_start = n_errors;
    check_value("reset_tx", 32'd1, 32'(uart_tx));
    check_value("reset_ack", 32'd0, 32'(wb_ack));
    for (int i = 0; i < 16; i++) begin
        wb_read(4'(i), rd);
        check_value("reset_mem", 32'd0, rd);
        shadow[i] = '0;
    end
    finish_test("reset_state", err_start);

    // Words 5 and up are free, the lower ones are registers
    err_start = n_errors;
    for (int n = 0; n < 12; n++) begin
        adr = 4'(5 + $urandom % 11);
        wd  = $urandom;
        sel = 4'($urandom);
        wb_write(adr, wd, sel);
        for (int l = 0; l < 4; l++) begin
            if (sel[l]) begin
                shadow[adr][l*8 +: 8] = wd[l*8 +: 8];
            end
        end
        wb_read(adr, rd);
        check_value("mem_access", shadow[adr], rd);
    end
    finish_test("mem_access", err_start);

    err_start = n_errors;
    load_config(DIVIDER_ADDR, 32'd16);
    loop_byte("loopback_none", 8'($urandom));
    finish_test("loopback_none", err_start);

    err_start = n_errors;
    load_config(PARITY_ADDR, 32'(PARITY_EVEN));
    loop_byte("parity_even", 8'($urandom));
    load_config(PARITY_ADDR, 32'(PARITY_ODD));
    loop_byte("parity_odd", 8'($urandom));
    good    = 8'($urandom);
    bad     = good ^ 8'h3c;
    loop_en = 1'b0;
    // Odd parity wants an odd count of ones, so the bad frame gets the even bit
    send_frame(bad, ^bad);
    send_frame(good, ~^good);
    loop_en = 1'b1;
    run_cmd(RX_DATA_ADDR);
    wb_read(4'(RX_DATA_ADDR), rd);
    check_value("parity_drop", {24'h0, good}, rd);
    finish_test("parity_modes", err_start);

    err_start = n_errors;
    for (int i = 0; i < 3; i++) begin
        sent[i] = 8'($urandom);
        wb_write(4'(TX_DATA_ADDR), {24'h0, sent[i]}, 4'hf);
        run_cmd(TX_DATA_ADDR);
    end
    for (int i = 0; i < 3; i++) begin
        run_cmd(RX_DATA_ADDR);
        wb_read(4'(RX_DATA_ADDR), rd);
        check_value("queue_order", {24'h0, sent[i]}, rd);
    end
    finish_test("queue_order", err_start);

    // Let the last stop bit finish before the divider changes
    err_start = n_errors;
    repeat (2 * BIT_CYCLES) @(negedge clk);
    load_config(DIVIDER_ADDR, 32'd8);
    good = 8'($urandom) | 8'h01;
    wb_write(4'(TX_DATA_ADDR), {24'h0, good}, 4'hf);
    wb_write(4'(CTRL_ADDR), 32'(TX_DATA_ADDR), 4'hf);
    while (uart_tx) begin
        @(negedge clk);
    end
    low = 0;
    while (!uart_tx) begin
        low++;
        @(negedge clk);
    end
    check_value("start_bit_len", 32'd8, 32'(low));
    wait_idle();
    run_cmd(RX_DATA_ADDR);
    wb_read(4'(RX_DATA_ADDR), rd);
    check_value("divider_8_loop", {24'h0, good}, rd);
    finish_test("divider_change", err_start);

    n_errors += u_bram_uart_top.u_properties.fail_count;
    $display("tests: %0d, checks: %0d, failed: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

endmodule

// ==== bram_uart.f ====
hdl/bram_uart_pkg.sv
hdl/bram_uart_fifo.sv
hdl/bram_uart_tx.sv
hdl/bram_uart_rx.sv
hdl/bram_uart_dpram.sv
hdl/bram_uart_ctrl.sv
hdl/bram_uart_top.sv
tb/bram_uart_properties.sv
tb/bram_uart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module bram_uart_tb -f bram_uart.f -o bram_uart_sim

output=$(./obj_dir/bram_uart_sim || true)
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
